/* axi_link_slave.f */
logic/axi_link_pkg.sv
logic/tx_lane_if.sv
logic/phy_unpacker.sv
logic/receive_fifo.sv
logic/response_transmitter.sv
logic/phy_packer.sv
logic/axi_link_slave_top.sv
testbench/axi_link_slave_tb.sv

/* logic/axi_link_pkg.sv */
package axi_link_pkg;

  ////////////////////////////////////////
  // PHY word

  localparam int phy_width = 76;

  localparam int kind_lsb = 0;
  localparam int kind_width = 2;
  localparam int payload_lsb = 2;

  // Receive side credit returns
  localparam int rx_r_credit_bit = 71;
  localparam int rx_b_credit_bit = 72;

  // Transmit side credit returns
  localparam int tx_ar_credit_bit = 73;
  localparam int tx_aw_credit_bit = 74;
  localparam int tx_w_credit_bit = 75;

  typedef enum logic [kind_width-1:0] {
    frame_idle = 2'd0,
    frame_ar   = 2'd1,
    frame_aw   = 2'd2,
    frame_w    = 2'd3
  } frame_kind_t;

  typedef enum logic [kind_width-1:0] {
    resp_idle = 2'd0,
    resp_r    = 2'd1,
    resp_b    = 2'd2
  } resp_kind_t;

  ////////////////////////////////////////
  // AXI fields

  localparam int id_width = 4;
  localparam int size_width = 2;
  localparam int len_width = 8;
  localparam int burst_width = 2;
  localparam int addr_width = 48;
  localparam int data_width = 64;
  localparam int resp_width = 2;

  // Receive FIFO depths
  localparam int ar_depth = 8;
  localparam int aw_depth = 8;
  localparam int w_depth = 16;

  typedef struct packed {
    logic [id_width-1:0]    id;
    logic [size_width-1:0]  size;
    logic [len_width-1:0]   len;
    logic [burst_width-1:0] burst;
    logic [addr_width-1:0]  addr;
  } addr_req_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic                  last;
  } wdata_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic                  last;
    logic [resp_width-1:0] resp;
  } rresp_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [resp_width-1:0] resp;
  } bresp_t;

endpackage

/* logic/axi_link_slave_top.sv */
`timescale 1ns/1ps

module axi_link_slave_top #(
  parameter int ar_depth = axi_link_pkg::ar_depth,
  parameter int aw_depth = axi_link_pkg::aw_depth,
  parameter int w_depth = axi_link_pkg::w_depth
) (
  input  logic                                  clk_wr,
  input  logic                                  reset,

  input  logic                                  tx_online,
  input  logic                                  rx_online,
  input  logic [7:0]                            init_r_credit,
  input  logic [7:0]                            init_b_credit,

  output logic [axi_link_pkg::phy_width-1:0]    tx_phy0,
  input  logic [axi_link_pkg::phy_width-1:0]    rx_phy0,

  // AR channel
  output logic [axi_link_pkg::id_width-1:0]     user_arid,
  output logic [axi_link_pkg::size_width-1:0]   user_arsize,
  output logic [axi_link_pkg::len_width-1:0]    user_arlen,
  output logic [axi_link_pkg::burst_width-1:0]  user_arburst,
  output logic [axi_link_pkg::addr_width-1:0]   user_araddr,
  output logic                                  user_arvalid,
  input  logic                                  user_arready,

  // AW channel
  output logic [axi_link_pkg::id_width-1:0]     user_awid,
  output logic [axi_link_pkg::size_width-1:0]   user_awsize,
  output logic [axi_link_pkg::len_width-1:0]    user_awlen,
  output logic [axi_link_pkg::burst_width-1:0]  user_awburst,
  output logic [axi_link_pkg::addr_width-1:0]   user_awaddr,
  output logic                                  user_awvalid,
  input  logic                                  user_awready,

  // W channel
  output logic [axi_link_pkg::id_width-1:0]     user_wid,
  output logic [axi_link_pkg::data_width-1:0]   user_wdata,
  output logic                                  user_wlast,
  output logic                                  user_wvalid,
  input  logic                                  user_wready,

  // R channel
  input  logic [axi_link_pkg::id_width-1:0]     user_rid,
  input  logic [axi_link_pkg::data_width-1:0]   user_rdata,
  input  logic                                  user_rlast,
  input  logic [axi_link_pkg::resp_width-1:0]   user_rresp,
  input  logic                                  user_rvalid,
  output logic                                  user_rready,

  // B channel
  input  logic [axi_link_pkg::id_width-1:0]     user_bid,
  input  logic [axi_link_pkg::resp_width-1:0]   user_bresp,
  input  logic                                  user_bvalid,
  output logic                                  user_bready
);

  import axi_link_pkg::*;

  logic      ar_push;
  logic      aw_push;
  logic      w_push;
  addr_req_t ar_push_data;
  addr_req_t aw_push_data;
  wdata_t    w_push_data;
  addr_req_t ar_data;
  addr_req_t aw_data;
  wdata_t    w_data;
  rresp_t    r_data;
  bresp_t    b_data;
  logic      ar_credit;
  logic      aw_credit;
  logic      w_credit;

  tx_lane_if #(.payload_t(rresp_t)) r_lane ();
  tx_lane_if #(.payload_t(bresp_t)) b_lane ();

  ////////////////////////////////////////
  // Receive path

  phy_unpacker phy_unpacker_i (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .rx_online  (rx_online),
    .rx_phy     (rx_phy0),
    .ar_push    (ar_push),
    .aw_push    (aw_push),
    .w_push     (w_push),
    .ar_payload (ar_push_data),
    .aw_payload (aw_push_data),
    .w_payload  (w_push_data),
    .r_credit   (r_lane.credit),
    .b_credit   (b_lane.credit)
  );

  receive_fifo #(.payload_t(addr_req_t), .depth(ar_depth)) receive_fifo_ar (
    .clk_wr    (clk_wr),
    .reset     (reset),
    .push      (ar_push),
    .push_data (ar_push_data),
    .valid     (user_arvalid),
    .data      (ar_data),
    .ready     (user_arready),
    .credit    (ar_credit)
  );

  receive_fifo #(.payload_t(addr_req_t), .depth(aw_depth)) receive_fifo_aw (
    .clk_wr    (clk_wr),
    .reset     (reset),
    .push      (aw_push),
    .push_data (aw_push_data),
    .valid     (user_awvalid),
    .data      (aw_data),
    .ready     (user_awready),
    .credit    (aw_credit)
  );

  receive_fifo #(.payload_t(wdata_t), .depth(w_depth)) receive_fifo_w (
    .clk_wr    (clk_wr),
    .reset     (reset),
    .push      (w_push),
    .push_data (w_push_data),
    .valid     (user_wvalid),
    .data      (w_data),
    .ready     (user_wready),
    .credit    (w_credit)
  );

  assign user_arid    = ar_data.id;
  assign user_arsize  = ar_data.size;
  assign user_arlen   = ar_data.len;
  assign user_arburst = ar_data.burst;
  assign user_araddr  = ar_data.addr;

  assign user_awid    = aw_data.id;
  assign user_awsize  = aw_data.size;
  assign user_awlen   = aw_data.len;
  assign user_awburst = aw_data.burst;
  assign user_awaddr  = aw_data.addr;

  assign user_wid   = w_data.id;
  assign user_wdata = w_data.data;
  assign user_wlast = w_data.last;

  ////////////////////////////////////////
  // Transmit path

  assign r_data = '{id: user_rid, data: user_rdata, last: user_rlast, resp: user_rresp};
  assign b_data = '{id: user_bid, resp: user_bresp};

  response_transmitter #(.payload_t(rresp_t)) response_transmitter_r (
    .clk_wr      (clk_wr),
    .reset       (reset),
    .tx_online   (tx_online),
    .init_credit (init_r_credit),
    .valid       (user_rvalid),
    .data        (r_data),
    .ready       (user_rready),
    .lane        (r_lane)
  );

  response_transmitter #(.payload_t(bresp_t)) response_transmitter_b (
    .clk_wr      (clk_wr),
    .reset       (reset),
    .tx_online   (tx_online),
    .init_credit (init_b_credit),
    .valid       (user_bvalid),
    .data        (b_data),
    .ready       (user_bready),
    .lane        (b_lane)
  );

  phy_packer phy_packer_i (
    .clk_wr    (clk_wr),
    .reset     (reset),
    .r_lane    (r_lane),
    .b_lane    (b_lane),
    .ar_credit (ar_credit),
    .aw_credit (aw_credit),
    .w_credit  (w_credit),
    .tx_phy    (tx_phy0)
  );

endmodule

/* logic/phy_packer.sv */
`timescale 1ns/1ps

module phy_packer (
  input  logic                               clk_wr,
  input  logic                               reset,
  tx_lane_if.packer                          r_lane,
  tx_lane_if.packer                          b_lane,
  input  logic                               ar_credit,
  input  logic                               aw_credit,
  input  logic                               w_credit,
  output logic [axi_link_pkg::phy_width-1:0] tx_phy
);

  import axi_link_pkg::*;

  logic                 r_grant;
  logic                 b_grant;
  logic [phy_width-1:0] tx_word;

  ////////////////////////////////////////
  // Arbitration, R first

  assign r_grant = r_lane.req;
  assign b_grant = b_lane.req && !r_lane.req;

  assign r_lane.grant = r_grant;
  assign b_lane.grant = b_grant;

  ////////////////////////////////////////
  // Word assembly

  always_comb begin
    tx_word = '0;
    tx_word[kind_lsb +: kind_width] = resp_idle;
    if (r_grant) begin
      tx_word[kind_lsb +: kind_width] = resp_r;
      tx_word[payload_lsb +: $bits(rresp_t)] = r_lane.payload;
    end else if (b_grant) begin
      tx_word[kind_lsb +: kind_width] = resp_b;
      tx_word[payload_lsb +: $bits(bresp_t)] = b_lane.payload;
    end
    // Credit bits ride along with any frame
    tx_word[tx_ar_credit_bit] = ar_credit;
    tx_word[tx_aw_credit_bit] = aw_credit;
    tx_word[tx_w_credit_bit] = w_credit;
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_word;
    end
  end

endmodule

/* logic/phy_unpacker.sv */
`timescale 1ns/1ps

module phy_unpacker (
  input  logic                                clk_wr,
  input  logic                                reset,
  input  logic                                rx_online,
  input  logic [axi_link_pkg::phy_width-1:0]  rx_phy,
  output logic                                ar_push,
  output logic                                aw_push,
  output logic                                w_push,
  output axi_link_pkg::addr_req_t             ar_payload,
  output axi_link_pkg::addr_req_t             aw_payload,
  output axi_link_pkg::wdata_t                w_payload,
  output logic                                r_credit,
  output logic                                b_credit
);

  import axi_link_pkg::*;

  frame_kind_t kind;
  logic        frame_valid;

  assign kind = frame_kind_t'(rx_phy[kind_lsb +: kind_width]);
  assign frame_valid = rx_online && (kind != frame_idle);

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ar_push  <= 1'b0;
      aw_push  <= 1'b0;
      w_push   <= 1'b0;
      r_credit <= 1'b0;
      b_credit <= 1'b0;
    end else begin
      ar_push  <= frame_valid && (kind == frame_ar);
      aw_push  <= frame_valid && (kind == frame_aw);
      w_push   <= frame_valid && (kind == frame_w);
      r_credit <= rx_online && rx_phy[rx_r_credit_bit];
      b_credit <= rx_online && rx_phy[rx_b_credit_bit];
    end
  end

  // Payload slices, qualified by the push bits
  always_ff @(posedge clk_wr) begin
    ar_payload <= addr_req_t'(rx_phy[payload_lsb +: $bits(addr_req_t)]);
    aw_payload <= addr_req_t'(rx_phy[payload_lsb +: $bits(addr_req_t)]);
    w_payload  <= wdata_t'(rx_phy[payload_lsb +: $bits(wdata_t)]);
  end

  ////////////////////////////////////////
  // Checks

  // Far end keeps the unused top bits clear
  reserved_bits_zero: assert property (
    @(posedge clk_wr) disable iff (reset)
    rx_phy[phy_width-1:rx_b_credit_bit+1] == '0
  ) else $error("rx_phy carries a reserved nonzero bit");

endmodule

/* logic/receive_fifo.sv */
`timescale 1ns/1ps

module receive_fifo #(
  parameter type payload_t = logic,
  parameter int  depth = 8
) (
  input  logic     clk_wr,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  output logic     valid,
  output payload_t data,
  input  logic     ready,
  output logic     credit
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width = $clog2(depth + 1);

  payload_t               mem [depth];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;
  logic                   pop;

  // Show-ahead with the head entry always on the output
  assign valid = (count != '0);
  assign data = mem[rd_ptr];
  assign pop = valid && ready;

  always_ff @(posedge clk_wr) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back to the far end per popped entry
      credit <= pop;
    end
  end

  ////////////////////////////////////////
  // Checks

  // Credits on the far end should make this impossible
  no_push_when_full: assert property (
    @(posedge clk_wr) disable iff (reset)
    push |-> (count != count_width'(depth))
  ) else $error("push into a full receive FIFO");

endmodule

/* logic/response_transmitter.sv */
`timescale 1ns/1ps

module response_transmitter #(
  parameter type payload_t = logic
) (
  input  logic       clk_wr,
  input  logic       reset,
  input  logic       tx_online,
  input  logic [7:0] init_credit,
  input  logic       valid,
  input  payload_t   data,
  output logic       ready,
  tx_lane_if.transmitter lane
);

  logic [7:0] credit_count;
  logic [7:0] credit_in;
  logic [7:0] credit_out;

  assign credit_in = {7'd0, lane.credit};
  assign credit_out = {7'd0, lane.grant};

  ////////////////////////////////////////
  // Credit counter

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_count <= '0;
    end else if (!tx_online) begin
      // Reload while the link is down
      credit_count <= init_credit;
    end else begin
      credit_count <= credit_count + credit_in - credit_out;
    end
  end

  ////////////////////////////////////////
  // Lane request

  assign lane.req = tx_online && (credit_count != '0) && valid;
  assign lane.payload = data;

  // AXI ready follows the packer grant
  assign ready = lane.grant;

  ////////////////////////////////////////
  // Checks

  grant_needs_req: assert property (
    @(posedge clk_wr) disable iff (reset)
    lane.grant |-> lane.req
  ) else $error("lane granted without a request");

  // Far end can never return more than it was given
  no_counter_wrap: assert property (
    @(posedge clk_wr) disable iff (reset)
    (tx_online && lane.credit && !lane.grant) |-> (credit_count != 8'hff)
  ) else $error("transmit credit counter wrapped");

endmodule

/* logic/tx_lane_if.sv */
`timescale 1ns/1ps

interface tx_lane_if #(
  parameter type payload_t = logic
);

  logic     req;
  payload_t payload;
  logic     grant;
  // Returned credit, one entry per pulse
  logic     credit;

  modport transmitter (
    output req,
    output payload,
    input  grant,
    input  credit
  );

  modport packer (
    input  req,
    input  payload,
    output grant
  );

endinterface

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the link slave testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module axi_link_slave_tb \
  -f axi_link_slave.f -o axi_link_slave_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/axi_link_slave_sim > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" || { echo "no result"; exit 1; }
exit 0

/* testbench/axi_link_slave_tb.sv */
`timescale 1ns/1ps

module axi_link_slave_tb;

  import axi_link_pkg::*;

  localparam int clk_period = 40;
  localparam int reset_cycles = 16;
  localparam int table_len = 10;
  localparam int random_w_beats = 24;
  localparam int response_items = 10;
  localparam int cycle_budget = 50;
  localparam int drain_limit = 400;
  localparam int test_items = table_len + random_w_beats + response_items;
  localparam int watchdog_ns = (test_items * cycle_budget + reset_cycles) * clk_period;

  // AR/AW rows use the address fields and W rows the data fields
  typedef struct packed {
    logic [1:0]  kind;
    logic [3:0]  id;
    logic [1:0]  size;
    logic [7:0]  len;
    logic [1:0]  burst;
    logic [47:0] addr;
    logic [63:0] data;
    logic        last;
  } row_t;

  logic                 clk_wr;
  logic                 reset;
  logic                 tx_online;
  logic                 rx_online;
  logic [7:0]           init_r_credit;
  logic [7:0]           init_b_credit;
  logic [phy_width-1:0] tx_phy0;
  logic [phy_width-1:0] rx_phy0;
  logic [3:0]  user_arid, user_awid, user_wid, user_rid, user_bid;
  logic [1:0]  user_arsize, user_awsize, user_arburst, user_awburst;
  logic [7:0]  user_arlen, user_awlen;
  logic [47:0] user_araddr, user_awaddr;
  logic [63:0] user_wdata, user_rdata;
  logic        user_wlast, user_rlast;
  logic [1:0]  user_rresp, user_bresp;
  logic user_arvalid, user_arready, user_awvalid, user_awready;
  logic user_wvalid, user_wready, user_rvalid, user_rready;
  logic user_bvalid, user_bready;

  row_t        stimulus [table_len];
  int          ar_expect[$];
  int          aw_expect[$];
  logic [68:0] w_expect[$];
  logic [72:0] tx_expect[$];
  int          far_credit [4];
  int          w_pops;
  int          w_credit_bits;
  int          fail_count;
  int          r_beat_no;
  logic        pressure_on;
  logic        ar_pop_d1, ar_pop_d2, aw_pop_d1, aw_pop_d2, w_pop_d1, w_pop_d2;
  logic [70:0] cur_r;
  logic [5:0]  cur_b;

  axi_link_slave_top #(
    .ar_depth (ar_depth),
    .aw_depth (aw_depth),
    .w_depth  (w_depth)
  ) uut (
    .clk_wr (clk_wr), .reset (reset),
    .tx_online (tx_online), .rx_online (rx_online),
    .init_r_credit (init_r_credit), .init_b_credit (init_b_credit),
    .tx_phy0 (tx_phy0), .rx_phy0 (rx_phy0),
    .user_arid (user_arid), .user_arsize (user_arsize), .user_arlen (user_arlen),
    .user_arburst (user_arburst), .user_araddr (user_araddr),
    .user_arvalid (user_arvalid), .user_arready (user_arready),
    .user_awid (user_awid), .user_awsize (user_awsize), .user_awlen (user_awlen),
    .user_awburst (user_awburst), .user_awaddr (user_awaddr),
    .user_awvalid (user_awvalid), .user_awready (user_awready),
    .user_wid (user_wid), .user_wdata (user_wdata), .user_wlast (user_wlast),
    .user_wvalid (user_wvalid), .user_wready (user_wready),
    .user_rid (user_rid), .user_rdata (user_rdata), .user_rlast (user_rlast),
    .user_rresp (user_rresp), .user_rvalid (user_rvalid), .user_rready (user_rready),
    .user_bid (user_bid), .user_bresp (user_bresp),
    .user_bvalid (user_bvalid), .user_bready (user_bready)
  );

  initial begin
    clk_wr = 1'b0;
    forever #(clk_period / 2) clk_wr = ~clk_wr;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: tests did not finish within %0d ns", watchdog_ns);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // Checks and helpers

  task compare_values(input string name, input logic [127:0] expected,
                      input logic [127:0] actual);
    if (expected !== actual) begin
      fail_count++;
      $display("mismatch in %s: expected %0h, actual %0h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task abort_run(input string reason);
    fail_count++;
    $display("error: %s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  // Receive word with kind in 1:0 and payload in 70:2
  // R credit in bit 71 and B credit in bit 72
  function automatic logic [phy_width-1:0] build_frame(input logic [1:0] kind,
      input logic [68:0] payload, input logic r_credit, input logic b_credit);
    logic [phy_width-1:0] word;
    word = '0;
    word[1:0] = kind;
    word[70:2] = payload;
    word[71] = r_credit;
    word[72] = b_credit;
    return word;
  endfunction

  function automatic logic [68:0] row_payload(input row_t row);
    if (row.kind == frame_w) begin
      return {row.id, row.data, row.last};
    end
    return {5'd0, row.id, row.size, row.len, row.burst, row.addr};
  endfunction

  task load_stimulus;
    stimulus[0] = '{frame_ar, 4'h1, 2'd3, 8'd0, 2'd1, 48'h0000_1000_0040, 64'd0, 1'b0};
    stimulus[1] = '{frame_aw, 4'h2, 2'd3, 8'd7, 2'd1, 48'h0000_2000_0000, 64'd0, 1'b0};
    stimulus[2] = '{frame_w, 4'h2, 2'd0, 8'd0, 2'd0, 48'd0, 64'h0123_4567_89ab_cdef, 1'b0};
    stimulus[3] = '{frame_w, 4'h2, 2'd0, 8'd0, 2'd0, 48'd0, 64'hfedc_ba98_7654_3210, 1'b1};
    stimulus[4] = '{frame_ar, 4'h5, 2'd2, 8'd15, 2'd2, 48'h7fff_ffff_fff0, 64'd0, 1'b0};
    stimulus[5] = '{frame_ar, 4'h6, 2'd0, 8'd255, 2'd0, 48'hffff_ffff_ffff, 64'd0, 1'b0};
    stimulus[6] = '{frame_aw, 4'h9, 2'd1, 8'd3, 2'd2, 48'h8000_0000_0100, 64'd0, 1'b0};
    stimulus[7] = '{frame_w, 4'h9, 2'd0, 8'd0, 2'd0, 48'd0, 64'hdead_beef_0000_0001, 1'b1};
    stimulus[8] = '{frame_aw, 4'hf, 2'd3, 8'd1, 2'd1, 48'h0000_0000_0000, 64'd0, 1'b0};
    stimulus[9] = '{frame_ar, 4'h0, 2'd3, 8'd31, 2'd1, 48'h1234_5678_9abc, 64'd0, 1'b0};
  endtask

  // Far end only sends while it holds a credit for the channel
  task send_frame(input logic [1:0] kind, input logic [68:0] payload);
    while (far_credit[kind] == 0) begin
      rx_phy0 <= '0;
      @(posedge clk_wr);
    end
    rx_phy0 <= build_frame(kind, payload, 1'b0, 1'b0);
    far_credit[kind] = far_credit[kind] - 1;
    @(posedge clk_wr);
  endtask

  task check_addr_beat(input string chan, input int idx, input logic [3:0] id,
      input logic [1:0] size, input logic [7:0] len, input logic [1:0] burst,
      input logic [47:0] addr);
    row_t row;
    row = stimulus[idx];
    compare_values($sformatf("%s row %0d id", chan, idx), row.id, id);
    compare_values($sformatf("%s row %0d size", chan, idx), row.size, size);
    compare_values($sformatf("%s row %0d len", chan, idx), row.len, len);
    compare_values($sformatf("%s row %0d burst", chan, idx), row.burst, burst);
    compare_values($sformatf("%s row %0d addr", chan, idx), row.addr, addr);
  endtask

  // R payload fields id, data, last and resp
  task present_r_beat(input int k);
    cur_r = {4'(k), $urandom, $urandom, k[0], 2'(k)};
    {user_rid, user_rdata, user_rlast, user_rresp} <= cur_r;
    user_rvalid <= 1'b1;
  endtask

  task count_r_accepts(input int window, output int accepted);
    logic took;
    accepted = 0;
    repeat (window) begin
      @(negedge clk_wr);
      took = user_rready;
      @(posedge clk_wr);
      if (took) begin
        accepted++;
        tx_expect.push_back({cur_r, 2'd1});
        r_beat_no++;
        present_r_beat(r_beat_no);
      end
    end
  endtask

  task wait_rx_drain;
    int guard;
    guard = 0;
    while (ar_expect.size() != 0 || aw_expect.size() != 0 || w_expect.size() != 0) begin
      @(posedge clk_wr);
      guard++;
      if (guard > drain_limit) begin
        abort_run("receive FIFOs did not deliver all expected beats");
      end
    end
    // Last credit bit lands two edges after the final pop
    repeat (3) @(posedge clk_wr);
  endtask

  task wait_tx_drain;
    int guard;
    guard = 0;
    while (tx_expect.size() != 0) begin
      @(posedge clk_wr);
      guard++;
      if (guard > cycle_budget) begin
        abort_run("expected response words never appeared on tx_phy0");
      end
    end
  endtask

  ////////////////////////////////////////
  // Random ready on the AXI sinks

  always @(posedge clk_wr) begin
    if (pressure_on) begin
      user_arready <= 1'($urandom % 2);
      user_awready <= 1'($urandom % 2);
      user_wready <= 1'($urandom % 2);
    end
  end

  ////////////////////////////////////////
  // Far-end monitor

  always @(negedge clk_wr) begin
    if (!reset) begin
      // Credit bit shows two edges after the pop
      compare_values("ar credit return", ar_pop_d2, tx_phy0[73]);
      compare_values("aw credit return", aw_pop_d2, tx_phy0[74]);
      compare_values("w credit return", w_pop_d2, tx_phy0[75]);
      far_credit[frame_ar] += int'(tx_phy0[73]);
      far_credit[frame_aw] += int'(tx_phy0[74]);
      far_credit[frame_w] += int'(tx_phy0[75]);
      w_credit_bits += int'(tx_phy0[75]);
      ar_pop_d2 = ar_pop_d1;
      aw_pop_d2 = aw_pop_d1;
      w_pop_d2 = w_pop_d1;
      ar_pop_d1 = user_arvalid && user_arready;
      aw_pop_d1 = user_awvalid && user_awready;
      w_pop_d1 = user_wvalid && user_wready;
      if (ar_pop_d1) begin
        if (ar_expect.size() == 0) abort_run("AR beat delivered with none expected");
        check_addr_beat("ar", ar_expect.pop_front(), user_arid, user_arsize,
                        user_arlen, user_arburst, user_araddr);
      end
      if (aw_pop_d1) begin
        if (aw_expect.size() == 0) abort_run("AW beat delivered with none expected");
        check_addr_beat("aw", aw_expect.pop_front(), user_awid, user_awsize,
                        user_awlen, user_awburst, user_awaddr);
      end
      if (w_pop_d1) begin
        if (w_expect.size() == 0) abort_run("W beat delivered with none expected");
        w_pops++;
        compare_values($sformatf("w beat %0d", w_pops), w_expect.pop_front(),
                       {user_wid, user_wdata, user_wlast});
      end
      // Response kind 1:0 and payload 72:2
      if (tx_phy0[1:0] != 2'd0) begin
        if (tx_expect.size() == 0) abort_run("response word sent with none expected");
        compare_values("transmitted response word", tx_expect.pop_front(), tx_phy0[72:0]);
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence

  initial begin
    int   accepted;
    int   guard;
    logic r_take;
    logic b_take;
    logic r_done;
    logic b_done;

    void'($urandom(32'h14bd));
    reset <= 1'b1;
    tx_online <= 1'b0;
    rx_online <= 1'b0;
    init_r_credit <= 8'd0;
    init_b_credit <= 8'd0;
    rx_phy0 <= '0;
    {user_arready, user_awready, user_wready} <= 3'b000;
    {user_rid, user_rdata, user_rlast, user_rresp, user_rvalid} <= '0;
    {user_bid, user_bresp, user_bvalid} <= '0;
    pressure_on <= 1'b0;
    {ar_pop_d1, ar_pop_d2, aw_pop_d1, aw_pop_d2, w_pop_d1, w_pop_d2} = '0;
    far_credit[frame_idle] = 0;
    far_credit[frame_ar] = ar_depth;
    far_credit[frame_aw] = aw_depth;
    far_credit[frame_w] = w_depth;
    w_pops = 0;
    w_credit_bits = 0;
    fail_count = 0;
    r_beat_no = 0;
    load_stimulus();

    repeat (reset_cycles) @(posedge clk_wr);
    reset <= 1'b0;
    rx_online <= 1'b1;

    @(negedge clk_wr);
    compare_values("arvalid after reset", 0, user_arvalid);
    compare_values("awvalid after reset", 0, user_awvalid);
    compare_values("wvalid after reset", 0, user_wvalid);
    compare_values("rready after reset", 0, user_rready);
    compare_values("bready after reset", 0, user_bready);
    compare_values("tx_phy0 after reset", 0, tx_phy0);

    // Table rows followed by random W beats under back-pressure
    @(posedge clk_wr);
    pressure_on <= 1'b1;
    for (int i = 0; i < table_len; i++) begin
      if (stimulus[i].kind == frame_ar) ar_expect.push_back(i);
      if (stimulus[i].kind == frame_aw) aw_expect.push_back(i);
      if (stimulus[i].kind == frame_w) w_expect.push_back(row_payload(stimulus[i]));
      send_frame(stimulus[i].kind, row_payload(stimulus[i]));
    end
    for (int i = 0; i < random_w_beats; i++) begin
      w_expect.push_back({4'($urandom), $urandom, $urandom, (i % 4) == 3});
      send_frame(frame_w, w_expect[w_expect.size() - 1]);
    end
    rx_phy0 <= '0;
    wait_rx_drain();
    compare_values("far-end ar credits at end", ar_depth, far_credit[frame_ar]);
    compare_values("far-end aw credits at end", aw_depth, far_credit[frame_aw]);
    compare_values("far-end w credits at end", w_depth, far_credit[frame_w]);
    compare_values("w credit bits per pop", w_pops, w_credit_bits);

    // R with three credits and then one returned credit
    @(posedge clk_wr);
    init_r_credit <= 8'd3;
    init_b_credit <= 8'd2;
    repeat (2) @(posedge clk_wr);
    tx_online <= 1'b1;
    present_r_beat(r_beat_no);
    count_r_accepts(12, accepted);
    compare_values("r beats on three credits", 3, accepted);
    rx_phy0 <= build_frame(frame_idle, '0, 1'b1, 1'b0);
    @(posedge clk_wr);
    rx_phy0 <= '0;
    count_r_accepts(12, accepted);
    compare_values("r beats after one returned credit", 1, accepted);
    user_rvalid <= 1'b0;
    wait_tx_drain();

    // R and B offered together with R first
    tx_online <= 1'b0;
    init_r_credit <= 8'd4;
    init_b_credit <= 8'd4;
    repeat (2) @(posedge clk_wr);
    tx_online <= 1'b1;
    present_r_beat(7);
    tx_expect.push_back({cur_r, 2'd1});
    cur_b = {4'hc, 2'd1};
    {user_bid, user_bresp} <= cur_b;
    user_bvalid <= 1'b1;
    tx_expect.push_back({65'd0, cur_b, 2'd2});
    r_done = 1'b0;
    b_done = 1'b0;
    guard = 0;
    while (!(r_done && b_done)) begin
      @(negedge clk_wr);
      guard++;
      if (guard > cycle_budget) abort_run("R and B responses were not both accepted");
      if (!r_done && user_bready) abort_run("B granted while an R beat was pending");
      r_take = user_rready;
      b_take = user_bready;
      @(posedge clk_wr);
      if (r_take) begin
        r_done = 1'b1;
        user_rvalid <= 1'b0;
      end
      if (b_take) begin
        b_done = 1'b1;
        user_bvalid <= 1'b0;
      end
    end
    wait_tx_drain();
    repeat (4) @(posedge clk_wr);

    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
